/* sim/tb_stage_controller.sv */
`timescale 1ns/1ns

module tb_stage_controller;

    import decoder_pkg::*;

    // eight rounds of margin plus two full deadlock waits
    localparam int round_cycles = 300;
    localparam int cycle_limit = 8 * round_cycles + 2 * deadlock_threshold + 60;

    logic clk;
    logic reset;
    logic new_round_start;
    logic has_message_flying;
    logic has_message_flying_other;
    logic has_odd_clusters;
    logic has_odd_clusters_other;
    logic cmd_ready;
    logic frame_valid;
    frame_msg_t frame_data;
    logic cmd_valid;
    command_msg_t cmd_data;
    logic frame_ready;
    stage_t stage;
    logic result_valid;
    frame_table_t frame_table;
    logic deadlock;
    logic [iteration_width-1:0] iteration_count;
    logic [31:0] cycle_count;

    // partner model state
    logic [31:0] rng_state;
    logic backpressure;
    int stretch_left;
    cmd_op_t received[$];
    frame_msg_t pending[$];
    frame_table_t expected_table;
    frame_msg_t new_frame;

    int elapsed_cycles;
    int check_errors;
    int test_start_errors;
    int tests_run;
    int tests_failed;
    int measured;
    int round_length;
    cmd_op_t expected_ops[$];

    stage_controller_top dut (
        .clk(clk), .reset(reset), .new_round_start(new_round_start),
        .has_message_flying(has_message_flying),
        .has_message_flying_other(has_message_flying_other),
        .has_odd_clusters(has_odd_clusters), .has_odd_clusters_other(has_odd_clusters_other),
        .cmd_ready(cmd_ready), .frame_valid(frame_valid), .frame_data(frame_data),
        .cmd_valid(cmd_valid), .cmd_data(cmd_data), .frame_ready(frame_ready),
        .stage(stage), .result_valid(result_valid), .frame_table(frame_table),
        .deadlock(deadlock), .iteration_count(iteration_count), .cycle_count(cycle_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        lcg_step = state * 32'd1664525 + 32'd1013904223;
    endfunction

    // a stalled command must stay on the bus unchanged
    command_held: assert property (
        @(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && cmd_data == $past(cmd_data)
    ) else begin
        $display("error: command word changed or vanished while cmd_ready was low");
        check_errors++;
    end

    deadlock_returns_idle: assert property (
        @(posedge clk) disable iff (reset) $rose(deadlock) |-> stage == stage_idle
    ) else begin
        $display("error: deadlock rose while the stage machine was not idle");
        check_errors++;
    end

    result_ends_round: assert property (
        @(posedge clk) disable iff (reset) $rose(result_valid) |-> stage == stage_idle
    ) else begin
        $display("error: result_valid rose without the round returning to idle");
        check_errors++;
    end

    always @(posedge clk) begin
        elapsed_cycles <= elapsed_cycles + 1;
        if (elapsed_cycles >= cycle_limit) begin
            $display("error: run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic drive_ready();
        if (!backpressure) begin
            cmd_ready = 1'b1;
        end else begin
            if (stretch_left == 0) begin
                rng_state = lcg_step(rng_state);
                cmd_ready = rng_state[27];
                stretch_left = int'(rng_state[18:16]) + 1;
            end
            stretch_left = stretch_left - 1;
        end
    endtask

    // partner answers op_finish with its data frames and an end marker
    task automatic queue_result_frames();
        for (int i = 0; i < frame_count; i++) begin
            rng_state = lcg_step(rng_state);
            new_frame.is_data = 1'b1;
            new_frame.touching = rng_state[24];
            new_frame.odd = rng_state[25];
            new_frame.root = rng_state[address_width+15:16];
            expected_table[i] = new_frame;
            pending.push_back(new_frame);
        end
        pending.push_back('0);
    endtask

    // transfers are recorded at the falling edge before the rising edge that takes them
    always @(negedge clk) begin
        if (!reset) begin
            drive_ready();
            if (cmd_valid && cmd_ready) begin
                received.push_back(cmd_data.opcode);
                if (cmd_data.opcode == op_finish) begin
                    queue_result_frames();
                end
            end
            if (pending.size() > 0 && frame_ready) begin
                frame_valid = 1'b1;
                frame_data = pending.pop_front();
            end else begin
                frame_valid = 1'b0;
                frame_data = '0;
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual == expected) else begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = check_errors;
        received.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (check_errors == test_start_errors) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, check_errors - test_start_errors);
        end
    endtask

    // returns with the round in stage_loading
    task automatic start_round();
        new_round_start = 1'b1;
        @(negedge clk);
        new_round_start = 1'b0;
    endtask

    task automatic wait_for_stage(input stage_t target);
        while (stage != target) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_for_result();
        while (!(result_valid && stage == stage_idle)) begin
            @(negedge clk);
        end
    endtask

    // counts cycles from stage_loading until the round is idle again
    task automatic time_round(output int cycles);
        cycles = 1;
        @(negedge clk);
        while (stage != stage_idle) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic measure_stage(input stage_t target, output int cycles);
        wait_for_stage(target);
        cycles = 0;
        while (stage == target) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic check_commands(input string name, input cmd_op_t expected[$]);
        while (received.size() < expected.size()) begin
            @(negedge clk);
        end
        check_value({name, " command count"}, 64'(expected.size()), 64'(received.size()));
        for (int i = 0; i < expected.size(); i++) begin
            check_value($sformatf("%s command %0d", name, i), 64'(expected[i]),
                        64'(received[i]));
        end
    endtask

    initial begin
        reset = 1'b1;
        new_round_start = 1'b0;
        has_message_flying = 1'b0;
        has_message_flying_other = 1'b0;
        has_odd_clusters = 1'b0;
        has_odd_clusters_other = 1'b0;
        cmd_ready = 1'b1;
        frame_valid = 1'b0;
        frame_data = '0;
        rng_state = 32'h07888a48;
        backpressure = 1'b0;
        stretch_left = 0;
        elapsed_cycles = 0;
        check_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        expected_table = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        begin_test();
        check_value("reset_state stage", 64'(stage_idle), 64'(stage));
        check_value("reset_state cmd_valid", 64'd0, 64'(cmd_valid));
        check_value("reset_state frame_ready", 64'd1, 64'(frame_ready));
        check_value("reset_state result_valid", 64'd0, 64'(result_valid));
        check_value("reset_state deadlock", 64'd0, 64'(deadlock));
        check_value("reset_state iteration_count", 64'd0, 64'(iteration_count));
        check_value("reset_state cycle_count", 64'd0, 64'(cycle_count));
        end_test("reset_state");
        @(negedge clk);

        begin_test();
        start_round();
        time_round(round_length);
        expected_ops = {op_advance, op_advance, op_finish};
        check_commands("clean_round", expected_ops);
        check_value("clean_round result_valid", 64'd1, 64'(result_valid));
        check_value("clean_round cycle_count", 64'(round_length), 64'(cycle_count));
        check_value("clean_round table", 64'(expected_table), 64'(frame_table));
        check_value("clean_round iteration_count", 64'd1, 64'(iteration_count));
        end_test("clean_round");

        // local odd flag for the first sync exit, partner flag for the second
        begin_test();
        has_odd_clusters = 1'b1;
        start_round();
        wait_for_stage(stage_grow);
        has_odd_clusters = 1'b0;
        has_odd_clusters_other = 1'b1;
        wait_for_stage(stage_spread);
        wait_for_stage(stage_grow);
        has_odd_clusters_other = 1'b0;
        wait_for_result();
        expected_ops.delete();
        repeat (8) expected_ops.push_back(op_advance);
        expected_ops.push_back(op_finish);
        check_commands("odd_iterations", expected_ops);
        check_value("odd_iterations table", 64'(expected_table), 64'(frame_table));
        check_value("odd_iterations iteration_count", 64'd3, 64'(iteration_count));
        end_test("odd_iterations");

        begin_test();
        has_odd_clusters = 1'b1;
        start_round();
        measure_stage(stage_spread, measured);
        check_value("minimum_delays spread cycles", 64'd7, 64'(measured));
        measure_stage(stage_grow, measured);
        has_odd_clusters = 1'b0;
        check_value("minimum_delays grow cycles", 64'd8, 64'(measured));
        wait_for_result();
        check_value("minimum_delays iteration_count", 64'd2, 64'(iteration_count));
        end_test("minimum_delays");

        begin_test();
        backpressure = 1'b1;
        has_odd_clusters_other = 1'b1;
        start_round();
        wait_for_stage(stage_grow);
        has_odd_clusters_other = 1'b0;
        wait_for_result();
        expected_ops.delete();
        repeat (5) expected_ops.push_back(op_advance);
        expected_ops.push_back(op_finish);
        check_commands("backpressure", expected_ops);
        check_value("backpressure table", 64'(expected_table), 64'(frame_table));
        backpressure = 1'b0;
        end_test("backpressure");

        // partner never goes quiet, so spread can only end by the watchdog
        begin_test();
        has_message_flying_other = 1'b1;
        start_round();
        while (!deadlock) begin
            @(negedge clk);
        end
        check_value("deadlock stage", 64'(stage_idle), 64'(stage));
        expected_ops = {op_advance, op_abort};
        check_commands("deadlock", expected_ops);
        has_message_flying_other = 1'b0;
        start_round();
        check_value("deadlock cleared by new round", 64'd0, 64'(deadlock));
        wait_for_result();
        end_test("deadlock");

        $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 tests_run, tests_run - tests_failed, tests_failed, check_errors);
        if (check_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog/decoder_pkg.sv */
package decoder_pkg;

    // code geometry
    localparam int code_distance_x = 3;
    localparam int code_distance_z = 3;
    localparam int measurement_rounds =
        (code_distance_x > code_distance_z) ? code_distance_x : code_distance_z;
    localparam int per_dimension_width = $clog2(measurement_rounds);
    localparam int address_width = per_dimension_width * 3;
    localparam int pu_count = code_distance_x * code_distance_z * measurement_rounds;

    // partner half owns right_block units in every row
    localparam int right_block = ((code_distance_x - 1) ** 2) / 2;
    localparam int frame_count = code_distance_x * right_block;
    localparam int frame_index_width = $clog2(frame_count + 1);

    // minimum stage lengths, the extra 4 cycles pay for the boundary crossing
    localparam int grow_delay = 3 + 4;
    localparam int spread_delay = 2 + 4;
    localparam int sync_delay = 2 + 4;
    // grow has the longest wait, so it sizes the counter
    localparam int delay_width = $clog2(grow_delay + 1);

    localparam int deadlock_threshold = pu_count * 10;
    localparam int stall_width = $clog2(deadlock_threshold + 2);

    localparam int fifo_depth = 16;
    localparam int iteration_width = 8;

    typedef enum logic [2:0] {
        stage_idle    = 3'd0,
        stage_loading = 3'd1,
        stage_spread  = 3'd2,
        stage_grow    = 3'd3,
        stage_sync    = 3'd4,
        stage_result  = 3'd5
    } stage_t;

    typedef enum logic [2:0] {
        op_advance = 3'd1,
        op_finish  = 3'd2,
        op_abort   = 3'd3
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t opcode;
    } command_msg_t;

    // is_data low marks the end of the partner's result stream
    typedef struct packed {
        logic                     is_data;
        logic                     touching;
        logic                     odd;
        logic [address_width-1:0] root;
    } frame_msg_t;

    typedef frame_msg_t [frame_count-1:0] frame_table_t;

endpackage

/* verilog/frame_collector.sv */
`timescale 1ns/1ns

module frame_collector (
    input  logic                      clk,
    input  logic                      reset,
    input  decoder_pkg::stage_t       stage,
    input  decoder_pkg::frame_msg_t   fifo_data,
    input  logic                      fifo_empty,
    output logic                      fifo_pop,
    output logic                      frames_done,
    output decoder_pkg::frame_table_t frame_table,
    output logic                      result_valid
);

    import decoder_pkg::*;

    logic [frame_index_width-1:0] frame_index;
    logic collecting;
    logic store_frame;

    // drain one word per cycle, only while the result stage is active
    assign collecting = (stage == stage_result) && !fifo_empty;
    assign fifo_pop = collecting;
    assign store_frame = collecting && fifo_data.is_data;
    assign frames_done = collecting && !fifo_data.is_data;

    always_ff @(posedge clk) begin
        if (store_frame) begin
            frame_table[frame_index] <= fifo_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_index <= '0;
            result_valid <= 1'b0;
        end else begin
            if (stage == stage_loading) begin
                // new round, start over at slot 0
                frame_index <= '0;
                result_valid <= 1'b0;
            end else if (frames_done) begin
                result_valid <= 1'b1;
            end else if (store_frame) begin
                frame_index <= frame_index + 1'b1;
            end
        end
    end

    // partner sends at most frame_count data words before its end marker
    index_in_range: assert property (
        @(posedge clk) disable iff (reset)
        frame_index <= frame_index_width'(frame_count)
    );

endmodule

/* verilog/round_monitor.sv */
`timescale 1ns/1ns

module round_monitor (
    input  logic                                  clk,
    input  logic                                  reset,
    input  decoder_pkg::stage_t                   stage,
    input  logic                                  new_round_start,
    input  logic                                  result_valid,
    output logic                                  stall_limit,
    output logic                                  deadlock,
    output logic [decoder_pkg::iteration_width-1:0] iteration_count,
    output logic [31:0]                           cycle_count
);

    import decoder_pkg::*;

    logic [stall_width-1:0] stall_count;
    logic in_stall_window;
    stage_t prev_stage;

    // spread and sync are where a lost message would hang the round
    assign in_stall_window = (stage == stage_spread) || (stage == stage_sync);
    assign stall_limit = stall_count > stall_width'(deadlock_threshold);

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_count <= '0;
            deadlock <= 1'b0;
            prev_stage <= stage_idle;
            iteration_count <= '0;
            cycle_count <= '0;
        end else begin
            prev_stage <= stage;

            if (!in_stall_window) begin
                stall_count <= '0;
            end else if (!stall_limit) begin
                stall_count <= stall_count + 1'b1;
            end

            // sticky until the next round is started
            if (new_round_start) begin
                deadlock <= 1'b0;
            end else if (stall_limit) begin
                deadlock <= 1'b1;
            end

            // one iteration per exit from sync
            if (stage == stage_loading) begin
                iteration_count <= '0;
            end else if (prev_stage == stage_sync &&
                         (stage == stage_grow || stage == stage_result)) begin
                iteration_count <= iteration_count + 1'b1;
            end

            if (stage == stage_loading) begin
                cycle_count <= 32'd1;
            end else if (!result_valid) begin
                cycle_count <= cycle_count + 32'd1;
            end
        end
    end

endmodule

/* verilog/stage_controller_top.sv */
`timescale 1ns/1ns

module stage_controller_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  new_round_start,
    input  logic                                  has_message_flying,
    input  logic                                  has_message_flying_other,
    input  logic                                  has_odd_clusters,
    input  logic                                  has_odd_clusters_other,
    input  logic                                  cmd_ready,
    input  logic                                  frame_valid,
    input  decoder_pkg::frame_msg_t               frame_data,
    output logic                                  cmd_valid,
    output decoder_pkg::command_msg_t             cmd_data,
    output logic                                  frame_ready,
    output decoder_pkg::stage_t                   stage,
    output logic                                  result_valid,
    output decoder_pkg::frame_table_t             frame_table,
    output logic                                  deadlock,
    output logic [decoder_pkg::iteration_width-1:0] iteration_count,
    output logic [31:0]                           cycle_count
);

    import decoder_pkg::*;

    command_msg_t seq_cmd_data;
    logic cmd_push;
    logic cmd_empty;
    frame_msg_t head_frame;
    logic frame_full;
    logic frame_empty;
    logic frame_pop;
    logic frames_done;
    logic stall_limit;

    assign cmd_valid = !cmd_empty;
    assign frame_ready = !frame_full;

    // commands towards the partner half
    sync_fifo #(.payload_t(command_msg_t), .depth(fifo_depth)) cmd_fifo (
        .clk(clk), .reset(reset),
        .push(cmd_push), .push_data(seq_cmd_data),
        .pop(cmd_ready && !cmd_empty), .pop_data(cmd_data),
        .full(), .empty(cmd_empty)
    );

    // result frames from the partner half
    sync_fifo #(.payload_t(frame_msg_t), .depth(fifo_depth)) frame_fifo (
        .clk(clk), .reset(reset),
        .push(frame_valid && !frame_full), .push_data(frame_data),
        .pop(frame_pop), .pop_data(head_frame),
        .full(frame_full), .empty(frame_empty)
    );

    frame_collector collector (
        .clk(clk), .reset(reset), .stage(stage),
        .fifo_data(head_frame), .fifo_empty(frame_empty), .fifo_pop(frame_pop),
        .frames_done(frames_done), .frame_table(frame_table), .result_valid(result_valid)
    );

    stage_sequencer sequencer (
        .clk(clk), .reset(reset), .new_round_start(new_round_start),
        .has_message_flying(has_message_flying),
        .has_message_flying_other(has_message_flying_other),
        .has_odd_clusters(has_odd_clusters), .has_odd_clusters_other(has_odd_clusters_other),
        .frames_done(frames_done), .stall_limit(stall_limit),
        .stage(stage), .cmd_push(cmd_push), .cmd_data(seq_cmd_data)
    );

    round_monitor monitor (
        .clk(clk), .reset(reset), .stage(stage),
        .new_round_start(new_round_start), .result_valid(result_valid),
        .stall_limit(stall_limit), .deadlock(deadlock),
        .iteration_count(iteration_count), .cycle_count(cycle_count)
    );

endmodule

/* verilog/stage_sequencer.sv */
`timescale 1ns/1ns

module stage_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      new_round_start,
    input  logic                      has_message_flying,
    input  logic                      has_message_flying_other,
    input  logic                      has_odd_clusters,
    input  logic                      has_odd_clusters_other,
    input  logic                      frames_done,
    input  logic                      stall_limit,
    output decoder_pkg::stage_t       stage,
    output logic                      cmd_push,
    output decoder_pkg::command_msg_t cmd_data
);

    import decoder_pkg::*;

    stage_t next_stage;
    logic [delay_width-1:0] delay_count;
    logic flying_any;
    logic odd_any;

    // both halves must be quiet before a stage may end
    assign flying_any = has_message_flying || has_message_flying_other;
    assign odd_any = has_odd_clusters || has_odd_clusters_other;

    always_comb begin
        next_stage = stage;
        cmd_push = 1'b0;
        cmd_data.opcode = op_advance;
        case (stage)
            stage_idle: begin
                if (new_round_start) begin
                    next_stage = stage_loading;
                    cmd_push = 1'b1;
                end
            end
            stage_loading: begin
                // single cycle, measurements come straight from the buffer
                next_stage = stage_spread;
            end
            stage_spread: begin
                if (delay_count >= delay_width'(spread_delay)) begin
                    if (!flying_any) begin
                        next_stage = stage_sync;
                        cmd_push = 1'b1;
                    end else if (stall_limit) begin
                        next_stage = stage_idle;
                        cmd_push = 1'b1;
                        cmd_data.opcode = op_abort;
                    end
                end
            end
            stage_grow: begin
                if (delay_count >= delay_width'(grow_delay) && !flying_any) begin
                    next_stage = stage_spread;
                    cmd_push = 1'b1;
                end
            end
            stage_sync: begin
                if (delay_count >= delay_width'(sync_delay)) begin
                    if (!flying_any) begin
                        cmd_push = 1'b1;
                        if (odd_any) begin
                            next_stage = stage_grow;
                        end else begin
                            next_stage = stage_result;
                            cmd_data.opcode = op_finish;
                        end
                    end else if (stall_limit) begin
                        next_stage = stage_idle;
                        cmd_push = 1'b1;
                        cmd_data.opcode = op_abort;
                    end
                end
            end
            stage_result: begin
                // partner's end marker closes the round
                if (frames_done) begin
                    next_stage = stage_idle;
                end
            end
            default: begin
                next_stage = stage_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= stage_idle;
            delay_count <= '0;
        end else begin
            stage <= next_stage;
            if (next_stage != stage) begin
                delay_count <= '0;
            end else if (delay_count < delay_width'(grow_delay)) begin
                // holds at the longest delay while messages are in flight
                delay_count <= delay_count + 1'b1;
            end
        end
    end

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 16
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int pointer_width = $clog2(depth);
    localparam int count_width = $clog2(depth + 1);

    payload_t mem [depth];
    logic [pointer_width-1:0] read_ptr;
    logic [pointer_width-1:0] write_ptr;
    logic [count_width-1:0] count;
    logic do_push;
    logic do_pop;

    assign full = (count == count_width'(depth));
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // head word is always on the output
    assign pop_data = mem[read_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[write_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            read_ptr <= '0;
            write_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                write_ptr <= (write_ptr == pointer_width'(depth - 1)) ? '0 : write_ptr + 1'b1;
            end
            if (do_pop) begin
                read_ptr <= (read_ptr == pointer_width'(depth - 1)) ? '0 : read_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer must respect full, consumer must respect empty
    no_push_when_full: assert property (@(posedge clk) disable iff (reset) !(push && full));
    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

/* vlog.f */
verilog/decoder_pkg.sv
verilog/sync_fifo.sv
verilog/frame_collector.sv
verilog/stage_sequencer.sv
verilog/round_monitor.sv
verilog/stage_controller_top.sv
sim/tb_stage_controller.sv
